/* compile.f */
hdl/coreinfo_pkg.sv
hdl/reg_bus_if.sv
hdl/burst_beat_counter.sv
hdl/axi_read_ctrl.sv
hdl/axi_write_ctrl.sv
hdl/core_info_regs.sv
hdl/coreinfo_top.sv
test/tb_clock_gen.sv
test/coreinfo_assertions.sv
test/coreinfo_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run the testbench and pass only when its pass message shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps --top-module coreinfo_tb \
	-f compile.f -o coreinfo_sim || { echo "Verilator build failed"; exit 1; }
out=$(./obj_dir/coreinfo_sim +verilator+error+limit+1000 2>&1)
echo "$out"
echo "$out" | grep -qF '** PASS **' && exit 0 || exit 1

/* test/coreinfo_tb.sv */
// Top-level testbench that drives AXI reads and writes into coreinfo_top under random stalls
`default_nettype none

module coreinfo_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int TIMEOUT = 50;   // Cycles allowed per handshake

	logic                             clk_i, rst_n;
	coreinfo_pkg::axi_id_t            arid, rid, awid, bid;
	coreinfo_pkg::axi_addr_t          araddr, awaddr;
	coreinfo_pkg::axi_len_t           arlen;
	coreinfo_pkg::word_t              rdata, wdata;
	logic [1:0]                       rresp, bresp;
	logic                             arvalid, arready, rlast, rvalid, rready;
	logic                             awvalid, awready, wlast, wvalid, wready, bvalid, bready;
	logic [coreinfo_pkg::N_CORES-1:0] core_rst_n, exp_rst_n;

	int                  errors;
	int                  seed;
	coreinfo_pkg::word_t wr_beats[$];   // Data beats of the next write burst

	tb_clock_gen clkgen (.clk_i(clk_i), .rst_n(rst_n));

	coreinfo_top uut (.*);

	task automatic next_cycle();
		@(posedge clk_i);
		#2;   // Drive and sample away from the edge
	endtask

	function automatic logic draw_ready();
		logic [31:0] r;
		r = $random(seed);
		return r[1:0] != 2'b00;   // Ready three cycles out of four
	endfunction

	task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
			input string what);
		assert (got == exp) else begin
			errors++;
			$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic report_timeout(input string what);
		errors++;
		$display("Timeout at %0t: the %s handshake did not complete within %0d cycles",
			$time, what, TIMEOUT);
	endtask

	// Expected read data from the register map and the core ID table
	function automatic coreinfo_pkg::word_t expected_read(input coreinfo_pkg::reg_sel_t sel,
			input coreinfo_pkg::axi_id_t id);
		coreinfo_pkg::word_t v;
		v = '0;
		if (sel == coreinfo_pkg::REG_N_CORES) begin
			v = 32'(coreinfo_pkg::N_CORES);
		end else if (sel == coreinfo_pkg::REG_CORE_ID) begin
			v = coreinfo_pkg::UNKNOWN_CORE_ID;
			for (int c = 0; c < coreinfo_pkg::N_CORES; c++) begin
				if (id == coreinfo_pkg::CORE_AXI_ID[c]) v = coreinfo_pkg::CORE_ID[c];
			end
		end
		return v;
	endfunction

	// Core 0 and unknown IDs are ignored
	task automatic apply_write_model(input coreinfo_pkg::reg_sel_t sel,
			input coreinfo_pkg::word_t data);
		for (int c = 1; c < coreinfo_pkg::N_CORES; c++) begin
			if (data == coreinfo_pkg::CORE_ID[c] && sel == coreinfo_pkg::REG_SET_RST)
				exp_rst_n[c] = 1'b0;
			if (data == coreinfo_pkg::CORE_ID[c] && sel == coreinfo_pkg::REG_CLR_RST)
				exp_rst_n[c] = 1'b1;
		end
	endtask

	task automatic axi_read(input coreinfo_pkg::axi_id_t id, input coreinfo_pkg::reg_sel_t sel,
			input coreinfo_pkg::axi_len_t len);
		coreinfo_pkg::word_t exp;
		int n;
		exp = expected_read(sel, id);
		arid = id;
		araddr = {8'h00, sel, 2'b00};
		arlen = len;
		arvalid = 1'b1;
		n = 0;
		while (!arready && n < TIMEOUT) begin
			next_cycle();
			n++;
		end
		if (!arready) begin
			report_timeout("AR");
			arvalid = 1'b0;
			return;
		end
		next_cycle();
		arvalid = 1'b0;
		for (int beat = 0; beat <= int'(len); beat++) begin
			rready = draw_ready();
			n = 0;
			while (!(rvalid && rready) && n < TIMEOUT) begin
				next_cycle();
				rready = draw_ready();   // Random stall per cycle
				n++;
			end
			if (!(rvalid && rready)) begin
				report_timeout("R");
				rready = 1'b0;
				return;
			end
			check_equal(rdata, exp, "rdata");
			check_equal(32'(rid), 32'(id), "rid");
			check_equal(32'(rlast), 32'(beat == int'(len)), "rlast");
			check_equal(32'(rresp), '0, "rresp");
			next_cycle();
		end
		rready = 1'b0;
		check_equal(32'(rvalid), '0, "rvalid after the last beat");
	endtask

	task automatic axi_write(input coreinfo_pkg::axi_id_t id, input coreinfo_pkg::reg_sel_t sel);
		int n;
		awid = id;
		awaddr = {8'h00, sel, 2'b00};
		awvalid = 1'b1;
		n = 0;
		while (!awready && n < TIMEOUT) begin
			next_cycle();
			n++;
		end
		if (!awready) begin
			report_timeout("AW");
			awvalid = 1'b0;
			return;
		end
		next_cycle();
		awvalid = 1'b0;
		for (int i = 0; i < wr_beats.size(); i++) begin
			wdata = wr_beats[i];
			wlast = (i == wr_beats.size() - 1);
			wvalid = 1'b1;
			n = 0;
			while (!wready && n < TIMEOUT) begin
				next_cycle();
				n++;
			end
			if (!wready) begin
				report_timeout("W");
				wvalid = 1'b0;
				return;
			end
			next_cycle();
			apply_write_model(sel, wr_beats[i]);
			check_equal(32'(core_rst_n), 32'(exp_rst_n), "core_rst_n after W beat");
		end
		wvalid = 1'b0;
		wlast = 1'b0;
		bready = draw_ready();
		n = 0;
		while (!(bvalid && bready) && n < TIMEOUT) begin
			next_cycle();
			bready = draw_ready();
			n++;
		end
		if (!(bvalid && bready)) report_timeout("B");
		check_equal(32'(bid), 32'(id), "bid");
		check_equal(32'(bresp), '0, "bresp");
		next_cycle();
		bready = 1'b0;
		check_equal(32'(core_rst_n), 32'(exp_rst_n), "core_rst_n after write");
		wr_beats.delete();
	endtask

	task automatic write_word(input coreinfo_pkg::axi_id_t id, input coreinfo_pkg::reg_sel_t sel,
			input coreinfo_pkg::word_t data);
		wr_beats.push_back(data);
		axi_write(id, sel);
	endtask

	initial begin
		int n;
		logic [31:0] r;
		coreinfo_pkg::axi_id_t id;
		errors = 0;
		seed = 32'h4104_aceb;
		arid = '0;
		araddr = '0;
		arlen = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		awid = '0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wlast = 1'b0;
		wvalid = 1'b0;
		bready = 1'b0;
		exp_rst_n = '0;
		exp_rst_n[0] = 1'b1;   // Boot core runs once reset is released
		n = 0;
		while (rst_n !== 1'b1 && n < TIMEOUT) begin
			@(posedge clk_i);
			n++;
		end
		if (rst_n !== 1'b1) report_timeout("reset release");
		next_cycle();

		check_equal(32'(core_rst_n), 32'(exp_rst_n), "core_rst_n after reset");
		check_equal(32'(rvalid), '0, "rvalid after reset");
		check_equal(32'(bvalid), '0, "bvalid after reset");
		axi_read(coreinfo_pkg::CORE_AXI_ID[0], coreinfo_pkg::REG_N_CORES, '0);

		// Core ID lookup with known and unknown AXI IDs
		for (int c = 0; c < coreinfo_pkg::N_CORES; c++) begin
			axi_read(coreinfo_pkg::CORE_AXI_ID[c], coreinfo_pkg::REG_CORE_ID, '0);
		end
		axi_read(4'h0, coreinfo_pkg::REG_CORE_ID, '0);
		axi_read(4'hc, coreinfo_pkg::REG_CORE_ID, '0);
		axi_read(coreinfo_pkg::CORE_AXI_ID[1], coreinfo_pkg::REG_SET_RST, '0);
		axi_read(coreinfo_pkg::CORE_AXI_ID[2], coreinfo_pkg::REG_CORE_ID, 8'd3);
		axi_read(coreinfo_pkg::CORE_AXI_ID[3], coreinfo_pkg::REG_N_CORES, 8'd3);

		write_word(4'h2, coreinfo_pkg::REG_CLR_RST, coreinfo_pkg::CORE_ID[2]);
		write_word(4'h5, coreinfo_pkg::REG_SET_RST, coreinfo_pkg::CORE_ID[2]);
		write_word(4'h7, coreinfo_pkg::REG_CLR_RST, 32'hdead_beef);
		write_word(4'h1, coreinfo_pkg::REG_CLR_RST, coreinfo_pkg::CORE_ID[0]);
		write_word(4'h3, coreinfo_pkg::REG_SET_RST, coreinfo_pkg::CORE_ID[0]);
		write_word(4'h4, coreinfo_pkg::REG_N_CORES, coreinfo_pkg::CORE_ID[1]);   // Read-only word

		// One burst releases several cores before its single response
		wr_beats = '{coreinfo_pkg::CORE_ID[1], coreinfo_pkg::CORE_ID[3],
			coreinfo_pkg::CORE_ID[2]};
		axi_write(4'h9, coreinfo_pkg::REG_CLR_RST);

		for (int k = 0; k < 24; k++) begin
			r = $random(seed);
			id = r[4] ? coreinfo_pkg::CORE_AXI_ID[r[3:2]] : r[11:8];
			if (r[0]) begin
				axi_read(id, r[6:5], {6'b0, r[13:12]});
			end else begin
				wr_beats.push_back(coreinfo_pkg::CORE_ID[r[15:14]]);
				if (r[16]) wr_beats.push_back(coreinfo_pkg::CORE_ID[r[18:17]]);
				if (r[19]) wr_beats.push_back(r);   // Matches no core
				axi_write(id, r[6:5]);
			end
		end

		next_cycle();
		$display("Summary: %0d value errors, %0d assertion failures",
			errors, uut.prot_checks.fail_count);
		if (errors == 0 && uut.prot_checks.fail_count == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* test/coreinfo_assertions.sv */
// AXI protocol checks bound into coreinfo_top; failures raise $error and bump a counter
`default_nettype none

module coreinfo_assertions (
	input logic                             clk_i,
	input logic                             rst_n,
	input logic                             rvalid, rready, rlast,
	input coreinfo_pkg::word_t              rdata,
	input coreinfo_pkg::axi_id_t            rid,
	input logic                             bvalid, bready,
	input coreinfo_pkg::axi_id_t            bid,
	input logic                             awvalid, awready, wvalid, wready, wlast,
	input logic [coreinfo_pkg::N_CORES-1:0] core_rst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	int   fail_count = 0;   // Read by the testbench summary
	logic in_burst;         // Between an accepted AW and the wlast beat

	always_ff @(posedge clk_i) begin
		if (!rst_n) begin
			in_burst <= 1'b0;
		end else if (awvalid && awready) begin
			in_burst <= 1'b1;
		end else if (wvalid && wready && wlast) begin
			in_burst <= 1'b0;
		end
	end

	r_hold: assert property (@(posedge clk_i) disable iff (!rst_n)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rid) && $stable(rlast))
		else begin
			$error("R channel changed while rready was low");
			fail_count++;
		end

	b_hold: assert property (@(posedge clk_i) disable iff (!rst_n)
		bvalid && !bready |=> bvalid && $stable(bid))
		else begin
			$error("B channel changed while bready was low");
			fail_count++;
		end

	rlast_needs_rvalid: assert property (@(posedge clk_i) disable iff (!rst_n)
		rlast |-> rvalid)
		else begin
			$error("rlast high without rvalid");
			fail_count++;
		end

	// Boot core reset is tied to the system reset, also during reset
	boot_core_rst: assert property (@(posedge clk_i) core_rst_n[0] == rst_n)
		else begin
			$error("core_rst_n[0] differs from rst_n");
			fail_count++;
		end

	wready_in_burst: assert property (@(posedge clk_i) disable iff (!rst_n)
		wready |-> in_burst)
		else begin
			$error("wready high outside a write burst");
			fail_count++;
		end

endmodule

bind coreinfo_top coreinfo_assertions prot_checks (
	.clk_i      (clk_i),
	.rst_n      (rst_n),
	.rvalid     (rvalid),
	.rready     (rready),
	.rlast      (rlast),
	.rdata      (rdata),
	.rid        (rid),
	.bvalid     (bvalid),
	.bready     (bready),
	.bid        (bid),
	.awvalid    (awvalid),
	.awready    (awready),
	.wvalid     (wvalid),
	.wready     (wready),
	.wlast      (wlast),
	.core_rst_n (core_rst_n)
);

`default_nettype wire

/* test/tb_clock_gen.sv */
// Testbench clock and reset source: 20 ns clock, reset held low for two rising edges
`default_nettype none

module tb_clock_gen (
	output logic clk_i,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk_i = 1'b0;
		forever #10 clk_i = ~clk_i;   // 20 ns period
	end

	initial begin
		rst_n = 1'b0;
		repeat (2) @(posedge clk_i);
		#2 rst_n = 1'b1;   // Released with the other stimulus
	end

endmodule

`default_nettype wire

/* hdl/coreinfo_top.sv */
// Core info and core reset peripheral top level with plain AXI4 slave ports
`default_nettype none

module coreinfo_top (
	input  logic                                clk_i,
	input  logic                                rst_n,
	// AR channel
	input  coreinfo_pkg::axi_id_t               arid,
	input  coreinfo_pkg::axi_addr_t             araddr,
	input  coreinfo_pkg::axi_len_t              arlen,
	input  logic                                arvalid,
	output logic                                arready,
	// R channel
	output coreinfo_pkg::axi_id_t               rid,
	output coreinfo_pkg::word_t                 rdata,
	output logic [1:0]                          rresp,
	output logic                                rlast,
	output logic                                rvalid,
	input  logic                                rready,
	// AW channel
	input  coreinfo_pkg::axi_id_t               awid,
	input  coreinfo_pkg::axi_addr_t             awaddr,
	input  logic                                awvalid,
	output logic                                awready,
	// W channel
	input  coreinfo_pkg::word_t                 wdata,
	input  logic                                wlast,
	input  logic                                wvalid,
	output logic                                wready,
	// B channel
	output coreinfo_pkg::axi_id_t               bid,
	output logic [1:0]                          bresp,
	output logic                                bvalid,
	input  logic                                bready,
	// Per-core resets, active low
	output logic [coreinfo_pkg::N_CORES-1:0]    core_rst_n
);

	// Beat counter steering
	logic                   cnt_load;
	coreinfo_pkg::axi_len_t cnt_length;
	logic                   cnt_step;
	logic                   cnt_last;

	reg_bus_if bus ();

	axi_read_ctrl u_read (
		.clk_i   (clk_i),
		.rst_n   (rst_n),
		.arid    (arid),
		.araddr  (araddr),
		.arlen   (arlen),
		.arvalid (arvalid),
		.arready (arready),
		.rid     (rid),
		.rdata   (rdata),
		.rresp   (rresp),
		.rlast   (rlast),
		.rvalid  (rvalid),
		.rready  (rready),
		.load    (cnt_load),
		.length  (cnt_length),
		.step    (cnt_step),
		.last    (cnt_last),
		.bus     (bus.rd_master)
	);

	burst_beat_counter u_beats (
		.clk_i  (clk_i),
		.rst_n  (rst_n),
		.load   (cnt_load),
		.length (cnt_length),
		.step   (cnt_step),
		.last   (cnt_last)
	);

	axi_write_ctrl u_write (
		.clk_i   (clk_i),
		.rst_n   (rst_n),
		.awid    (awid),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wlast   (wlast),
		.wvalid  (wvalid),
		.wready  (wready),
		.bid     (bid),
		.bresp   (bresp),
		.bvalid  (bvalid),
		.bready  (bready),
		.bus     (bus.wr_master)
	);

	core_info_regs u_regs (
		.clk_i      (clk_i),
		.rst_n      (rst_n),
		.core_rst_n (core_rst_n),
		.bus        (bus.regs)
	);

endmodule

`default_nettype wire

/* hdl/core_info_regs.sv */
// Core info registers: AXI ID to core ID lookup, read decode and secondary core reset flags
`default_nettype none

module core_info_regs (
	input  logic                                clk_i,
	input  logic                                rst_n,
	output logic [coreinfo_pkg::N_CORES-1:0]    core_rst_n,
	reg_bus_if.regs                             bus
);

	coreinfo_pkg::core_id_t core_id_q;

	// Core is released when its flag is set, core 0 has none
	logic [coreinfo_pkg::N_CORES-1:1] release_q;

	// Registered table lookup, one cycle behind rd_axi_id
	always_ff @(posedge clk_i) begin
		core_id_q <= coreinfo_pkg::UNKNOWN_CORE_ID;
		for (int i = 0; i < coreinfo_pkg::N_CORES; i++) begin
			if (bus.rd_axi_id == coreinfo_pkg::CORE_AXI_ID[i]) begin
				core_id_q <= coreinfo_pkg::CORE_ID[i];
			end
		end
	end

	always_comb begin
		case (bus.rd_sel)
			coreinfo_pkg::REG_N_CORES: bus.rd_data = coreinfo_pkg::word_t'(coreinfo_pkg::N_CORES);
			coreinfo_pkg::REG_CORE_ID: bus.rd_data = core_id_q;
			default:                   bus.rd_data = '0;   // Write-only words read as zero
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n) begin
			release_q <= '0;   // All secondary cores held in reset
		end else if (bus.wr_en) begin
			for (int i = 1; i < coreinfo_pkg::N_CORES; i++) begin
				if (bus.wr_data == coreinfo_pkg::CORE_ID[i]) begin
					if (bus.wr_sel == coreinfo_pkg::REG_SET_RST) begin
						release_q[i] <= 1'b0;
					end else if (bus.wr_sel == coreinfo_pkg::REG_CLR_RST) begin
						release_q[i] <= 1'b1;
					end
				end
			end
		end
	end

	// Boot core follows the system reset
	assign core_rst_n = {release_q, rst_n};

endmodule

`default_nettype wire

/* hdl/axi_write_ctrl.sv */
// AXI4 AW/W/B channel controller; turns each W beat into a register bus write
`default_nettype none

module axi_write_ctrl (
	input  logic                    clk_i,
	input  logic                    rst_n,
	// AW channel
	input  coreinfo_pkg::axi_id_t   awid,
	input  coreinfo_pkg::axi_addr_t awaddr,
	input  logic                    awvalid,
	output logic                    awready,
	// W channel
	input  coreinfo_pkg::word_t     wdata,
	input  logic                    wlast,
	input  logic                    wvalid,
	output logic                    wready,
	// B channel
	output coreinfo_pkg::axi_id_t   bid,
	output logic [1:0]              bresp,
	output logic                    bvalid,
	input  logic                    bready,
	reg_bus_if.wr_master            bus
);

	coreinfo_pkg::wr_state_t state_q;
	coreinfo_pkg::axi_id_t   id_q;
	coreinfo_pkg::reg_sel_t  sel_q;

	logic aw_xfer;
	logic w_xfer;
	logic b_xfer;

	assign aw_xfer = awvalid && awready;
	assign w_xfer  = wvalid && wready;
	assign b_xfer  = bvalid && bready;

	always_ff @(posedge clk_i) begin
		if (!rst_n) begin
			state_q <= coreinfo_pkg::WR_IDLE;
		end else begin
			case (state_q)
				coreinfo_pkg::WR_IDLE: begin
					if (aw_xfer) state_q <= coreinfo_pkg::WR_DATA;
				end
				coreinfo_pkg::WR_DATA: begin
					if (w_xfer && wlast) state_q <= coreinfo_pkg::WR_RESP;   // Burst ends at wlast
				end
				coreinfo_pkg::WR_RESP: begin
					if (b_xfer) state_q <= coreinfo_pkg::WR_IDLE;
				end
				default: state_q <= coreinfo_pkg::WR_IDLE;
			endcase
		end
	end

	// Address phase payload
	always_ff @(posedge clk_i) begin
		if (aw_xfer) begin
			id_q  <= awid;
			sel_q <= awaddr[3:2];
		end
	end

	assign awready = (state_q == coreinfo_pkg::WR_IDLE);
	assign wready  = (state_q == coreinfo_pkg::WR_DATA);
	assign bvalid  = (state_q == coreinfo_pkg::WR_RESP);
	assign bid     = id_q;
	assign bresp   = 2'b00;   // Always OKAY

	// One write per accepted beat, applied by the register block at the next edge
	assign bus.wr_en   = w_xfer;
	assign bus.wr_sel  = sel_q;
	assign bus.wr_data = wdata;

endmodule

`default_nettype wire

/* hdl/axi_read_ctrl.sv */
// AXI4 AR/R channel controller; steers the beat counter and reads through the register bus
`default_nettype none

module axi_read_ctrl (
	input  logic                    clk_i,
	input  logic                    rst_n,
	// AR channel
	input  coreinfo_pkg::axi_id_t   arid,
	input  coreinfo_pkg::axi_addr_t araddr,
	input  coreinfo_pkg::axi_len_t  arlen,
	input  logic                    arvalid,
	output logic                    arready,
	// R channel
	output coreinfo_pkg::axi_id_t   rid,
	output coreinfo_pkg::word_t     rdata,
	output logic [1:0]              rresp,
	output logic                    rlast,
	output logic                    rvalid,
	input  logic                    rready,
	// Beat counter
	output logic                    load,
	output coreinfo_pkg::axi_len_t  length,
	output logic                    step,
	input  logic                    last,
	reg_bus_if.rd_master            bus
);

	coreinfo_pkg::rd_state_t state_q;
	coreinfo_pkg::axi_id_t   id_q;
	coreinfo_pkg::reg_sel_t  sel_q;

	logic ar_xfer;
	logic r_xfer;

	assign ar_xfer = arvalid && arready;
	assign r_xfer  = rvalid && rready;

	always_ff @(posedge clk_i) begin
		if (!rst_n) begin
			state_q <= coreinfo_pkg::RD_IDLE;
		end else begin
			case (state_q)
				coreinfo_pkg::RD_IDLE: begin
					if (ar_xfer) state_q <= coreinfo_pkg::RD_LOOKUP;
				end
				coreinfo_pkg::RD_LOOKUP: begin
					state_q <= coreinfo_pkg::RD_DATA;   // Core ID lookup settles here
				end
				coreinfo_pkg::RD_DATA: begin
					if (r_xfer && last) state_q <= coreinfo_pkg::RD_IDLE;
				end
				default: state_q <= coreinfo_pkg::RD_IDLE;
			endcase
		end
	end

	// Request payload, held for the whole burst
	always_ff @(posedge clk_i) begin
		if (ar_xfer) begin
			id_q  <= arid;
			sel_q <= araddr[3:2];
		end
	end

	assign arready = (state_q == coreinfo_pkg::RD_IDLE);
	assign rvalid  = (state_q == coreinfo_pkg::RD_DATA);
	assign rlast   = rvalid && last;
	assign rid     = id_q;
	assign rdata   = bus.rd_data;   // Same register on every beat
	assign rresp   = 2'b00;         // Always OKAY

	assign load    = ar_xfer;
	assign length  = arlen;
	assign step    = r_xfer;

	assign bus.rd_sel    = sel_q;
	assign bus.rd_axi_id = id_q;

endmodule

`default_nettype wire

/* hdl/burst_beat_counter.sv */
// Counts read burst beats; loaded with ARLEN, stepped per beat, flags the final beat
`default_nettype none

module burst_beat_counter (
	input  logic                   clk_i,
	input  logic                   rst_n,
	input  logic                   load,
	input  coreinfo_pkg::axi_len_t length,
	input  logic                   step,
	output logic                   last
);

	coreinfo_pkg::axi_len_t count_q;
	coreinfo_pkg::axi_len_t length_q;

	always_ff @(posedge clk_i) begin
		if (!rst_n) begin
			count_q  <= '0;
			length_q <= '0;
		end else if (load) begin
			count_q  <= '0;      // New burst starts at beat 0
			length_q <= length;
		end else if (step && !last) begin
			count_q  <= count_q + 1'b1;
		end
	end

	// Final beat once the count reaches len-1 encoding
	assign last = (count_q == length_q);

endmodule

`default_nettype wire

/* hdl/reg_bus_if.sv */
// Register access bus between the AXI read/write controllers and the register block
`default_nettype none

interface reg_bus_if;

	// Read side
	coreinfo_pkg::reg_sel_t rd_sel;
	coreinfo_pkg::axi_id_t  rd_axi_id;   // ID of the core doing the read
	coreinfo_pkg::word_t    rd_data;

	// Write side, one wr_en pulse per W beat
	logic                   wr_en;
	coreinfo_pkg::reg_sel_t wr_sel;
	coreinfo_pkg::word_t    wr_data;

	modport rd_master (
		output rd_sel, rd_axi_id,
		input  rd_data
	);

	modport wr_master (
		output wr_en, wr_sel, wr_data
	);

	modport regs (
		input  rd_sel, rd_axi_id, wr_en, wr_sel, wr_data,
		output rd_data
	);

endinterface

`default_nettype wire

/* hdl/coreinfo_pkg.sv */
// Shared widths, register map, core ID tables and FSM state types for the core info block
`default_nettype none

package coreinfo_pkg;

	// AXI field widths
	typedef logic [3:0]  axi_id_t;
	typedef logic [11:0] axi_addr_t;
	typedef logic [7:0]  axi_len_t;   // Burst length minus one
	typedef logic [31:0] word_t;

	typedef logic [1:0]  reg_sel_t;   // Word index from address bits 3:2
	typedef logic [31:0] core_id_t;

	localparam int N_CORES = 4;

	// Register map, word indices
	localparam reg_sel_t REG_N_CORES = 2'd0;
	localparam reg_sel_t REG_CORE_ID = 2'd1;
	localparam reg_sel_t REG_SET_RST = 2'd2;
	localparam reg_sel_t REG_CLR_RST = 2'd3;

	// Issuing AXI ID of each core, index is the core number
	localparam axi_id_t CORE_AXI_ID [N_CORES] = '{4'd1, 4'd2, 4'd3, 4'd4};

	// Core ID reported to each core
	localparam core_id_t CORE_ID [N_CORES] = '{
		32'h0000_0100,
		32'h0000_0101,
		32'h0000_0102,
		32'h0000_0103
	};

	localparam core_id_t UNKNOWN_CORE_ID = '1;   // Returned when the AXI ID is not in the table

	typedef enum logic [1:0] {RD_IDLE, RD_LOOKUP, RD_DATA} rd_state_t;
	typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_RESP} wr_state_t;

endpackage

`default_nettype wire
